// File: list.f
verilog/mipsIsaPkg.sv
verilog/mipsPipePkg.sv
verilog/stageReg.sv
verilog/fetchUnit.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memWriteback.sv
verilog/mips.sv
verif/mipsTb.sv

// File: verif/mipsTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsTb import mipsIsaPkg::*; ();

    localparam int clkPeriod = 4;
    localparam int resetCycles = 16;
    localparam int drainCycles = 12;
    localparam int maxProg = 64;
    localparam int numTests = 6;
    localparam int cyclesPerInstr = 20;
    // each test gets reset, drain and a full-length program
    localparam int watchdogCycles =
        numTests * (resetCycles + drainCycles + 40 + cyclesPerInstr * maxProg);

    // key holds the register for a writeback or the address for a store
    typedef struct packed {
        wordT pc;
        wordT key;
        wordT data;
    } recordT;

    logic clk;
    logic reset;
    wordT imemAddr;
    wordT imemData;
    logic wbValid;
    wordT wbPc;
    regIdxT wbReg;
    wordT wbData;
    logic storeValid;
    wordT storePc;
    wordT storeAddr;
    wordT storeData;

    wordT imem [maxProg];
    int progLen;
    wordT fetchIdx;
    wordT modelReg [32];
    wordT modelMem [1024];
    recordT expWb [$];
    recordT expStore [$];
    recordT gotWb [$];
    recordT gotStore [$];
    string testName;
    wordT rngState;

    mips #(.dmemWords(1024)) mips_inst (.*);

    // instruction memory answers nops outside the program
    assign fetchIdx = (imemAddr - resetPc) >> 2;
    assign imemData = (fetchIdx < wordT'(progLen)) ? imem[fetchIdx[5:0]] : '0;

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        stopRun("watchdog expired before all tests finished");
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "first error ends the run");
    endtask

    task automatic check(input string what, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            stopRun($sformatf("MISMATCH %s %s expected %h actual %h",
                              testName, what, expected, actual));
        end
    endtask

    function automatic recordT makeRecord(input wordT pc, input wordT key, input wordT data);
        recordT r;
        r.pc = pc;
        r.key = key;
        r.data = data;
        return r;
    endfunction

    // trace outputs come from registers and are stable at the falling edge
    always @(negedge clk) begin
        if (wbValid) begin
            gotWb.push_back(makeRecord(wbPc, 32'(wbReg), wbData));
        end
        if (storeValid) begin
            gotStore.push_back(makeRecord(storePc, storeAddr, storeData));
        end
    end

    function automatic wordT nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic wordT rFormat(input functT fn, input int rd, input int rs, input int rt);
        return {opSpecial, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic wordT iFormat(input opcodeT op, input int rt, input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic wordT jFormat(input opcodeT op, input int addr);
        return {op, addr[27:2]};
    endfunction

    function automatic int pcOf(input int slot);
        return int'(resetPc) + 4 * slot;
    endfunction

    function automatic int memIndex(input wordT addr);
        return int'(addr[31:2] % 1024);
    endfunction

    task automatic retire(input wordT pc, input regIdxT idx, input wordT value);
        if (idx != '0) begin
            modelReg[idx] = value;
            expWb.push_back(makeRecord(pc, 32'(idx), value));
        end
    endtask

    // sequential reference model where npc carries the delay slot
    task automatic runModel();
        wordT pc;
        wordT npc;
        wordT target;
        wordT seq;
        wordT slot;
        wordT ins;
        wordT a;
        wordT b;
        wordT simm;
        int steps;
        for (int i = 0; i < 32; i++) begin
            modelReg[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            modelMem[i] = '0;
        end
        expWb.delete();
        expStore.delete();
        pc = resetPc;
        npc = resetPc + 32'd4;
        slot = '0;
        steps = 0;
        while (slot < wordT'(progLen)) begin
            ins = imem[slot[5:0]];
            seq = pc + 32'd4;
            target = npc + 32'd4;
            a = modelReg[ins[25:21]];
            b = modelReg[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            case (ins[31:26])
                opSpecial: begin
                    case (ins[5:0])
                        fnAddu: retire(pc, ins[15:11], a + b);
                        fnSubu: retire(pc, ins[15:11], a - b);
                        fnAnd: retire(pc, ins[15:11], a & b);
                        fnOr: retire(pc, ins[15:11], a | b);
                        fnSlt: retire(pc, ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        fnJr: target = a;
                        default: ;
                    endcase
                end
                opOri: retire(pc, ins[20:16], a | {16'h0, ins[15:0]});
                opLui: retire(pc, ins[20:16], {ins[15:0], 16'h0});
                opLw: retire(pc, ins[20:16], modelMem[memIndex(a + simm)]);
                opSw: begin
                    modelMem[memIndex(a + simm)] = b;
                    expStore.push_back(makeRecord(pc, a + simm, b));
                end
                opBeq: begin
                    if (a == b) begin
                        target = seq + (simm << 2);
                    end
                end
                opJ: target = {seq[31:28], ins[25:0], 2'b00};
                opJal: begin
                    target = {seq[31:28], ins[25:0], 2'b00};
                    retire(pc, 5'd31, pc + 32'd8);
                end
                default: ;
            endcase
            pc = npc;
            npc = target;
            slot = (pc - resetPc) >> 2;
            steps++;
            if (steps > 4 * maxProg) begin
                stopRun("reference model never left the program");
            end
        end
    endtask

    task automatic startTest(input string name);
        @(negedge clk);
        reset = 1'b1;
        testName = name;
        progLen = 0;
        for (int i = 0; i < maxProg; i++) begin
            imem[i] = '0;
        end
    endtask

    task automatic emit(input wordT instr);
        imem[progLen] = instr;
        progLen++;
    endtask

    task automatic runAndCompare();
        int limit;
        int cycles;
        runModel();
        repeat (resetCycles) @(negedge clk);
        gotWb.delete();
        gotStore.delete();
        reset = 1'b0;
        limit = cyclesPerInstr * progLen + 40;
        cycles = 0;
        while ((gotWb.size() < expWb.size() || gotStore.size() < expStore.size())
               && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        // extra cycles catch records that should not be there
        repeat (drainCycles) @(negedge clk);
        if (gotWb.size() != expWb.size() || gotStore.size() != expStore.size()) begin
            stopRun($sformatf("%s: expected %0d writebacks and %0d stores, DUT gave %0d and %0d",
                              testName, expWb.size(), expStore.size(),
                              gotWb.size(), gotStore.size()));
        end else begin
            foreach (expWb[i]) begin
                check($sformatf("writeback %0d pc", i), expWb[i].pc, gotWb[i].pc);
                check($sformatf("writeback %0d reg", i), expWb[i].key, gotWb[i].key);
                check($sformatf("writeback %0d data", i), expWb[i].data, gotWb[i].data);
            end
            foreach (expStore[i]) begin
                check($sformatf("store %0d pc", i), expStore[i].pc, gotStore[i].pc);
                check($sformatf("store %0d addr", i), expStore[i].key, gotStore[i].key);
                check($sformatf("store %0d data", i), expStore[i].data, gotStore[i].data);
            end
        end
    endtask

    task automatic testArithmetic();
        startTest("arithmetic");
        emit(iFormat(opLui, 1, 0, 'h1234));
        emit(iFormat(opOri, 1, 1, 'h5678));
        emit(iFormat(opOri, 2, 0, 'h00ff));
        emit(rFormat(fnAddu, 3, 1, 2));
        emit(rFormat(fnSubu, 4, 3, 1));
        emit(rFormat(fnAnd, 5, 4, 3));
        emit(rFormat(fnOr, 6, 5, 1));
        emit(rFormat(fnSlt, 7, 4, 6));
        emit(iFormat(opLui, 8, 0, 'hffff));
        emit(rFormat(fnSlt, 9, 8, 7));
        emit(rFormat(fnSubu, 10, 0, 9));
        emit(rFormat(fnAddu, 11, 10, 10));
        runAndCompare();
    endtask

    task automatic testLoadStore();
        startTest("load store");
        emit(iFormat(opOri, 1, 0, 'h0040));
        emit(iFormat(opOri, 2, 0, 'h1234));
        emit(iFormat(opSw, 2, 1, 0));
        emit(iFormat(opLui, 3, 0, 'habcd));
        emit(iFormat(opSw, 3, 1, 4));
        emit(iFormat(opLw, 4, 1, 0));
        emit(rFormat(fnAddu, 5, 4, 4));
        emit(iFormat(opLw, 6, 1, 4));
        emit(iFormat(opSw, 6, 1, 8));
        emit(iFormat(opLw, 7, 1, 8));
        emit(rFormat(fnOr, 8, 7, 0));
        emit(rFormat(fnSubu, 9, 7, 5));
        emit(iFormat(opSw, 5, 1, 12));
        emit(iFormat(opLw, 10, 1, 12));
        runAndCompare();
    endtask

    task automatic testBranches();
        startTest("branches");
        emit(iFormat(opOri, 1, 0, 5));
        emit(iFormat(opOri, 2, 0, 5));
        emit(iFormat(opBeq, 2, 1, 2));
        emit(iFormat(opOri, 3, 0, 1));
        emit(iFormat(opOri, 4, 0, 2));
        emit(iFormat(opOri, 5, 0, 3));
        emit(rFormat(fnAddu, 6, 1, 1));
        // not-taken beq on an operand from the ALU just ahead
        emit(iFormat(opBeq, 1, 6, 1));
        emit(iFormat(opOri, 7, 0, 4));
        emit(iFormat(opOri, 8, 0, 'h40));
        emit(iFormat(opSw, 6, 8, 0));
        emit(iFormat(opLw, 9, 8, 0));
        // taken beq on an operand from the load just ahead
        emit(iFormat(opBeq, 6, 9, 2));
        emit(iFormat(opOri, 10, 0, 7));
        emit(iFormat(opOri, 11, 0, 8));
        emit(iFormat(opOri, 12, 0, 9));
        emit(iFormat(opBeq, 0, 0, 2));
        emit(rFormat(fnAddu, 13, 9, 5));
        emit(iFormat(opOri, 14, 0, 1));
        emit(rFormat(fnSubu, 15, 13, 12));
        runAndCompare();
    endtask

    task automatic testJumps();
        startTest("jumps");
        emit(iFormat(opOri, 1, 0, 1));
        emit(jFormat(opJal, pcOf(6)));
        emit(iFormat(opOri, 2, 0, 2));
        emit(iFormat(opOri, 3, 0, 3));
        emit(jFormat(opJ, pcOf(10)));
        emit(iFormat(opOri, 4, 0, 4));
        // subroutine
        emit(rFormat(fnAddu, 5, 1, 2));
        emit(rFormat(fnJr, 0, 31, 0));
        emit(iFormat(opOri, 6, 0, 6));
        emit(iFormat(opOri, 7, 0, 7));
        emit(rFormat(fnAddu, 8, 31, 0));
        emit(iFormat(opOri, 10, 0, pcOf(15)));
        emit(rFormat(fnJr, 0, 10, 0));
        emit(iFormat(opOri, 11, 0, 11));
        emit(iFormat(opOri, 12, 0, 12));
        emit(iFormat(opOri, 13, 0, 13));
        emit(rFormat(fnAddu, 14, 31, 13));
        runAndCompare();
    endtask

    task automatic testRegisterZero();
        startTest("register zero");
        emit(iFormat(opOri, 0, 0, 'h55));
        emit(iFormat(opOri, 1, 0, 7));
        emit(iFormat(opLui, 0, 0, 'h1234));
        emit(rFormat(fnAddu, 2, 0, 1));
        emit(iFormat(opSw, 1, 0, 'h10));
        emit(iFormat(opLw, 0, 0, 'h10));
        emit(rFormat(fnAddu, 3, 0, 0));
        emit(rFormat(fnSubu, 4, 0, 2));
        emit(rFormat(fnOr, 0, 2, 1));
        emit(rFormat(fnAnd, 5, 0, 4));
        runAndCompare();
    endtask

    // registers 0 to 7 and sixteen memory words keep dependencies dense
    task automatic testRandomMix();
        wordT r;
        wordT imm;
        int rd;
        int rs;
        int rt;
        startTest("random mix");
        for (int i = 0; i < 40; i++) begin
            r = nextRandom();
            imm = nextRandom();
            rd = int'(r[10:8]);
            rs = int'(r[13:11]);
            rt = int'(r[16:14]);
            case (r[7:0] % 9)
                0: emit(rFormat(fnAddu, rd, rs, rt));
                1: emit(rFormat(fnSubu, rd, rs, rt));
                2: emit(rFormat(fnAnd, rd, rs, rt));
                3: emit(rFormat(fnOr, rd, rs, rt));
                4: emit(rFormat(fnSlt, rd, rs, rt));
                5: emit(iFormat(opOri, rd, rs, int'(imm[15:0])));
                6: emit(iFormat(opLui, rd, 0, int'(imm[15:0])));
                7: emit(iFormat(opLw, rd, 0, int'(imm[5:2]) * 4));
                default: emit(iFormat(opSw, rt, 0, int'(imm[5:2]) * 4));
            endcase
        end
        runAndCompare();
    endtask

    initial begin
        reset = 1'b1;
        progLen = 0;
        testName = "";
        rngState = 32'h308b_d021;
        testArithmetic();
        testLoadStore();
        testBranches();
        testJumps();
        testRegisterZero();
        testRandomMix();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import mipsIsaPkg::*, mipsPipePkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  wordT   decodePc,
    input  wordT   decodeInstr,
    input  regIdxT execDest,
    input  logic   execRegWrite,
    input  wordT   execValue,
    input  regIdxT memDest,
    input  logic   memRegWrite,
    input  wordT   memValue,
    input  logic   wbValid,
    input  regIdxT wbReg,
    input  wordT   wbData,
    input  wordT   fetchPc,
    output wordT   nextPc,
    output regIdxT readRs,
    output regIdxT readRt,
    output logic   isBranchOrJr,
    output wordT   dxPc,
    output ctrlT   dxCtrl,
    output wordT   dxRsVal,
    output wordT   dxRtVal,
    output wordT   dxImm,
    output wordT   dxPc8
);

    opcodeT opcode;
    functT funct;
    regIdxT rs;
    regIdxT rt;
    regIdxT rd;
    logic [immW-1:0] imm16;
    logic [targetW-1:0] target;
    ctrlT ctrl;
    wordT imm;
    wordT rsValue;
    wordT rtValue;
    wordT seqPc;
    wordT branchTarget;
    wordT regFile [32];

    assign opcode = decodeInstr[opLsb +: 6];
    assign funct = decodeInstr[5:0];
    assign rs = decodeInstr[rsLsb +: 5];
    assign rt = decodeInstr[rtLsb +: 5];
    assign rd = decodeInstr[rdLsb +: 5];
    assign imm16 = decodeInstr[0 +: immW];
    assign target = decodeInstr[0 +: targetW];

    // unused operands read as register 0 so they never cause a stall
    always_comb begin
        ctrl = '0;
        imm = {{16{imm16[15]}}, imm16};
        readRs = '0;
        readRt = '0;
        case (opcode)
            opSpecial: begin
                readRs = rs;
                readRt = rt;
                ctrl.dest = rd;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel = wbAlu;
                case (funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr: ctrl.aluOp = aluOr;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnJr: begin
                        readRt = '0;
                        ctrl = '0;
                        ctrl.jump = jmpJr;
                    end
                    default: begin
                        readRs = '0;
                        readRt = '0;
                        ctrl = '0;
                    end
                endcase
            end
            opOri, opLui: begin
                readRs = (opcode == opOri) ? rs : '0;
                imm = {16'h0, imm16};
                ctrl.dest = rt;
                ctrl.regWrite = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.aluOp = (opcode == opOri) ? aluOr : aluLui;
            end
            opLw: begin
                readRs = rs;
                ctrl.dest = rt;
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.wbSel = wbMem;
            end
            opSw: begin
                readRs = rs;
                readRt = rt;
                ctrl.memWrite = 1'b1;
                ctrl.useImm = 1'b1;
            end
            opBeq: begin
                readRs = rs;
                readRt = rt;
                ctrl.jump = jmpBeq;
            end
            opJ: ctrl.jump = jmpJ;
            opJal: begin
                ctrl.jump = jmpJ;
                ctrl.dest = 5'd31;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel = wbPc8;
            end
            default: ctrl = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbValid) begin
            regFile[wbReg] <= wbData;
        end
    end

    // register read sees the write of this same cycle
    function automatic wordT readReg(input regIdxT idx);
        return (wbValid && wbReg == idx) ? wbData : regFile[idx];
    endfunction

    // newest producer first
    function automatic wordT forwardOperand(input regIdxT idx);
        return (idx == '0) ? '0 :
               (execRegWrite && execDest == idx) ? execValue :
               (memRegWrite && memDest == idx) ? memValue : readReg(idx);
    endfunction

    assign rsValue = forwardOperand(readRs);
    assign rtValue = forwardOperand(readRt);
    assign seqPc = decodePc + 32'd4;
    assign branchTarget = seqPc + {{14{imm16[15]}}, imm16, 2'b00};

    always_comb begin
        case (ctrl.jump)
            jmpBeq: nextPc = (rsValue == rtValue) ? branchTarget : fetchPc + 32'd4;
            jmpJ: nextPc = {seqPc[31:28], target, 2'b00};
            jmpJr: nextPc = rsValue;
            default: nextPc = fetchPc + 32'd4;
        endcase
    end

    assign isBranchOrJr = (ctrl.jump == jmpBeq) || (ctrl.jump == jmpJr);

    assign dxPc = decodePc;
    assign dxCtrl = ctrl;
    assign dxRsVal = rsValue;
    assign dxRtVal = rtValue;
    assign dxImm = imm;
    assign dxPc8 = decodePc + 32'd8;

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import mipsIsaPkg::*, mipsPipePkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   flush,
    input  wordT   dxPc,
    input  ctrlT   dxCtrl,
    input  regIdxT dxRsIdx,
    input  regIdxT dxRtIdx,
    input  wordT   dxRsVal,
    input  wordT   dxRtVal,
    input  wordT   dxImm,
    input  wordT   dxPc8,
    input  regIdxT memDest,
    input  logic   memRegWrite,
    input  wordT   memValue,
    input  logic   wbValid,
    input  regIdxT wbReg,
    input  wordT   wbData,
    output wordT   execPc,
    output ctrlT   execCtrl,
    output wordT   execResult,
    output wordT   execStoreData,
    output logic   execReady
);

    decodeToExecT dxIn;
    decodeToExecT ex;
    wordT opA;
    wordT rtValue;
    wordT opB;
    wordT aluY;

    assign dxIn = '{pc: dxPc, ctrl: dxCtrl, rsIdx: dxRsIdx, rtIdx: dxRtIdx,
                    rsVal: dxRsVal, rtVal: dxRtVal, imm: dxImm, pc8: dxPc8};

    stageReg #(.payloadT(decodeToExecT)) decodeToExec (
        .clk(clk),
        .reset(reset),
        .enable(1'b1),
        .flush(flush),
        .d(dxIn),
        .q(ex)
    );

    // values that were still in flight when decoded
    function automatic wordT forwardOperand(input regIdxT idx, input wordT held);
        return (idx == '0) ? '0 :
               (memRegWrite && memDest == idx) ? memValue :
               (wbValid && wbReg == idx) ? wbData : held;
    endfunction

    assign opA = forwardOperand(ex.rsIdx, ex.rsVal);
    assign rtValue = forwardOperand(ex.rtIdx, ex.rtVal);
    assign opB = ex.ctrl.useImm ? ex.imm : rtValue;

    always_comb begin
        case (ex.ctrl.aluOp)
            aluAdd: aluY = opA + opB;
            aluSub: aluY = opA - opB;
            aluAnd: aluY = opA & opB;
            aluOr: aluY = opA | opB;
            aluSlt: aluY = {31'b0, $signed(opA) < $signed(opB)};
            aluLui: aluY = {opB[15:0], 16'h0};
            default: aluY = '0;
        endcase
    end

    // only the link value is usable by a branch in decode
    assign execReady = (ex.ctrl.wbSel == wbPc8);
    assign execResult = execReady ? ex.pc8 : aluY;
    assign execStoreData = rtValue;
    assign execPc = ex.pc;
    assign execCtrl = ex.ctrl;

endmodule

`default_nettype wire

// File: verilog/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import mipsIsaPkg::*, mipsPipePkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  wordT nextPc,
    output wordT pc,
    input  wordT imemData,
    output wordT decodePc,
    output wordT decodeInstr
);

    fetchToDecodeT fetched;
    fetchToDecodeT latched;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    assign fetched = '{pc: pc, instr: imemData};

    // decode register holds its word while stalled
    stageReg #(.payloadT(fetchToDecodeT)) fetchToDecode (
        .clk(clk),
        .reset(reset),
        .enable(!stall),
        .flush(1'b0),
        .d(fetched),
        .q(latched)
    );

    assign decodePc = latched.pc;
    assign decodeInstr = latched.instr;

endmodule

`default_nettype wire

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import mipsIsaPkg::*; (
    input  regIdxT readRs,
    input  regIdxT readRt,
    input  logic   isBranchOrJr,
    input  regIdxT execDest,
    input  logic   execRegWrite,
    input  logic   execReady,
    input  logic   execMemRead,
    input  regIdxT memDest,
    input  logic   memRegWrite,
    input  logic   memReady,
    output logic   stall,
    output logic   flushExec
);

    logic branchWait;
    logic loadUse;

    function automatic logic hitExec(input regIdxT idx);
        return idx != '0 && execRegWrite && execDest == idx;
    endfunction

    function automatic logic hitMem(input regIdxT idx);
        return idx != '0 && memRegWrite && memDest == idx;
    endfunction

    // a hit in execute hides any older hit in memory
    function automatic logic notReadyNow(input regIdxT idx);
        return hitExec(idx) ? !execReady : (hitMem(idx) && !memReady);
    endfunction

    // compare in decode needs its operands this cycle
    assign branchWait = isBranchOrJr && (notReadyNow(readRs) || notReadyNow(readRt));

    // other users can wait for memory forwarding, except behind a load
    assign loadUse = !isBranchOrJr && execMemRead && (hitExec(readRs) || hitExec(readRt));

    assign stall = branchWait || loadUse;
    assign flushExec = stall;

endmodule

`default_nettype wire

// File: verilog/memWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module memWriteback import mipsIsaPkg::*, mipsPipePkg::*; #(
    parameter int dmemWords = 1024
) (
    input  logic   clk,
    input  logic   reset,
    input  wordT   execPc,
    input  ctrlT   execCtrl,
    input  wordT   execResult,
    input  wordT   execStoreData,
    output regIdxT memDest,
    output logic   memRegWrite,
    output logic   memReady,
    output wordT   memValue,
    output logic   wbValid,
    output wordT   wbPc,
    output regIdxT wbReg,
    output wordT   wbData,
    output logic   storeValid,
    output wordT   storePc,
    output wordT   storeAddr,
    output wordT   storeData
);

    localparam int idxW = $clog2(dmemWords);

    execToMemT memIn;
    execToMemT memStage;
    memToWbT wbIn;
    memToWbT wbStage;
    wordT loadData;
    logic [idxW-1:0] dmemIdx;
    wordT dmem [dmemWords];

    assign memIn = '{pc: execPc, ctrl: execCtrl, result: execResult, storeData: execStoreData};

    stageReg #(.payloadT(execToMemT)) execToMem (
        .clk(clk),
        .reset(reset),
        .enable(1'b1),
        .flush(1'b0),
        .d(memIn),
        .q(memStage)
    );

    // word index wraps at dmemWords
    assign dmemIdx = idxW'(memStage.result[31:2] % dmemWords);
    assign loadData = dmem[dmemIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (memStage.ctrl.memWrite) begin
            dmem[dmemIdx] <= memStage.storeData;
        end
    end

    assign memDest = memStage.ctrl.dest;
    assign memRegWrite = memStage.ctrl.regWrite;
    assign memReady = !memStage.ctrl.memRead;
    assign memValue = memStage.result;

    assign wbIn = '{pc: memStage.pc, ctrl: memStage.ctrl,
                    value: (memStage.ctrl.wbSel == wbMem) ? loadData : memStage.result};

    stageReg #(.payloadT(memToWbT)) memToWb (
        .clk(clk),
        .reset(reset),
        .enable(1'b1),
        .flush(1'b0),
        .d(wbIn),
        .q(wbStage)
    );

    // writes to register 0 retire silently
    assign wbValid = wbStage.ctrl.regWrite && wbStage.ctrl.dest != '0;
    assign wbPc = wbStage.pc;
    assign wbReg = wbStage.ctrl.dest;
    assign wbData = wbStage.value;

    assign storeValid = memStage.ctrl.memWrite;
    assign storePc = memStage.pc;
    assign storeAddr = memStage.result;
    assign storeData = memStage.storeData;

endmodule

`default_nettype wire

// File: verilog/mips.sv
`timescale 1ns/1ps
`default_nettype none

module mips import mipsIsaPkg::*, mipsPipePkg::*; #(
    parameter int dmemWords = 1024
) (
    input  logic   clk,
    input  logic   reset,
    output wordT   imemAddr,
    input  wordT   imemData,
    output logic   wbValid,
    output wordT   wbPc,
    output regIdxT wbReg,
    output wordT   wbData,
    output logic   storeValid,
    output wordT   storePc,
    output wordT   storeAddr,
    output wordT   storeData
);

    wordT nextPc;
    wordT decodePc;
    wordT decodeInstr;
    regIdxT readRs;
    regIdxT readRt;
    logic isBranchOrJr;
    wordT dxPc;
    ctrlT dxCtrl;
    wordT dxRsVal;
    wordT dxRtVal;
    wordT dxImm;
    wordT dxPc8;
    logic stall;
    logic flushExec;
    wordT execPc;
    ctrlT execCtrl;
    wordT execResult;
    wordT execStoreData;
    logic execReady;
    regIdxT memDest;
    logic memRegWrite;
    logic memReady;
    wordT memValue;

    fetchUnit fetch (.pc(imemAddr), .*);

    decodeStage decode (
        .fetchPc(imemAddr),
        .execDest(execCtrl.dest),
        .execRegWrite(execCtrl.regWrite),
        .execValue(execResult),
        .*
    );

    hazardUnit hazard (
        .execDest(execCtrl.dest),
        .execRegWrite(execCtrl.regWrite),
        .execMemRead(execCtrl.memRead),
        .*
    );

    executeStage execute (.flush(flushExec), .dxRsIdx(readRs), .dxRtIdx(readRt), .*);

    memWriteback #(.dmemWords(dmemWords)) memWb (.*);

endmodule

`default_nettype wire

// File: verilog/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regIdxT;
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // first fetch address out of reset
    localparam wordT resetPc = 32'h0000_3000;

    // instruction field positions
    localparam int opLsb = 26;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;
    localparam int immW = 16;
    localparam int targetW = 26;

    // primary opcodes
    localparam opcodeT opSpecial = 6'h00;
    localparam opcodeT opJ = 6'h02;
    localparam opcodeT opJal = 6'h03;
    localparam opcodeT opBeq = 6'h04;
    localparam opcodeT opOri = 6'h0d;
    localparam opcodeT opLui = 6'h0f;
    localparam opcodeT opLw = 6'h23;
    localparam opcodeT opSw = 6'h2b;

    // funct codes under opSpecial
    localparam functT fnJr = 6'h08;
    localparam functT fnAddu = 6'h21;
    localparam functT fnSubu = 6'h23;
    localparam functT fnAnd = 6'h24;
    localparam functT fnOr = 6'h25;
    localparam functT fnSlt = 6'h2a;

endpackage

`default_nettype wire

// File: verilog/mipsPipePkg.sv
`default_nettype none

package mipsPipePkg;

    import mipsIsaPkg::*;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;
    typedef enum logic [1:0] {wbAlu, wbMem, wbPc8} wbSelT;
    typedef enum logic [1:0] {jmpNone, jmpBeq, jmpJ, jmpJr} jumpT;

    // all-zero value is a harmless bubble
    typedef struct packed {
        regIdxT dest;
        logic regWrite;
        logic memRead;
        logic memWrite;
        aluOpT aluOp;
        logic useImm;
        wbSelT wbSel;
        jumpT jump;
    } ctrlT;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } fetchToDecodeT;

    typedef struct packed {
        wordT pc;
        ctrlT ctrl;
        regIdxT rsIdx;
        regIdxT rtIdx;
        wordT rsVal;
        wordT rtVal;
        wordT imm;
        wordT pc8;
    } decodeToExecT;

    typedef struct packed {
        wordT pc;
        ctrlT ctrl;
        wordT result;
        wordT storeData;
    } execToMemT;

    typedef struct packed {
        wordT pc;
        ctrlT ctrl;
        wordT value;
    } memToWbT;

endpackage

`default_nettype wire

// File: verilog/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    enable,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // flush beats enable so a stalled slot becomes a bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire
